//--- sim.f
rtl/gfx_pkg.sv
rtl/display_pkg.sv
rtl/draw_line.sv
rtl/framebuffer.sv
rtl/vga_scanout.sv
rtl/line_display_top.sv
testbench/tb_line_display.sv

//--- run_sim.sh
#!/bin/sh
# build and run the line display testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_line_display -f sim.f -o tb_line_display
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_line_display)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- testbench/tb_line_display.sv
// testbench for the line drawing display subsystem
// draws lines through the top level, checks busy/done timing and whole captured frames
module tb_line_display import gfx_pkg::*, display_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LINES       = 28;  // 1 diagonal, 6 directions, 20 random, 1 busy test
    localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
    localparam int WATCHDOG_CYCLES = NUM_LINES * 30000 + 4 * FRAME_CYCLES;

    logic                    clk_pix = 1'b0;
    logic                    rst;
    logic                    start;
    logic signed [CORDW-1:0] x0, y0, x1, y1;
    logic [CIDXW-1:0]        cidx;
    logic                    busy, done;
    logic                    vga_hsync, vga_vsync, vga_de;
    logic [CHANW-1:0]        vga_r, vga_g, vga_b;

    logic [CIDXW-1:0]   shadow [FB_WIDTH*FB_HEIGHT];  // expected fb indices
    logic [31:0]        lfsr;
    logic [3*CHANW-1:0] exp_rgb;
    logic               exp_hs;
    string              test_name = "reset";
    int                 errors = 0;
    int                 frames_requested = 0;  // written by the main process only
    int                 frames_started = 0;    // these two by the comparing process
    int                 frames_checked = 0;
    int                 row = -1;              // -1 until the first vsync
    int                 col = 0;
    int                 hblank = -1;           // cycles since de fell, -1 in active video
    logic               prev_de = 1'b0;
    logic               prev_vs = 1'b1;
    bit                 capturing = 1'b0;

    line_display_top dut (.*);

    always #50 clk_pix = ~clk_pix;  // 100 ns period

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        $display("TB FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopped on failure");
    endtask

    // galois step, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // reference bresenham, later lines overwrite earlier ones
    function automatic void plot_line(input int ax0, ay0, ax1, ay1, input int c);
        int x, y, dx, dy, sx, sy, err, e2;
        x   = ax0;
        y   = ay0;
        dx  = (ax1 > ax0) ? ax1 - ax0 : ax0 - ax1;
        dy  = (ay1 > ay0) ? ay0 - ay1 : ay1 - ay0;  // negative |dy|
        sx  = (ax1 >= ax0) ? 1 : -1;
        sy  = (ay1 >= ay0) ? 1 : -1;
        err = dx + dy;
        while (1'b1) begin
            shadow[y * FB_WIDTH + x] = c[CIDXW-1:0];
            if (x == ax1 && y == ay1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    endfunction

    // display pixel to palette colour of its fb pixel
    function automatic logic [3*CHANW-1:0] expected_rgb(input int px, input int py);
        return palette_rgb(shadow[(py / FB_SCALE) * FB_WIDTH + px / FB_SCALE]);
    endfunction

    function automatic int line_cycles(input int ax0, ay0, ax1, ay1);
        int adx, ady;
        adx = (ax1 > ax0) ? ax1 - ax0 : ax0 - ax1;
        ady = (ay1 > ay0) ? ay1 - ay0 : ay0 - ay1;
        return ((adx > ady) ? adx : ady) + 1;  // one write per point
    endfunction

    // request one line, check busy rise and done timing
    task automatic draw_line_checked(input int ax0, ay0, ax1, ay1, input int c,
                                     input bit poke);
        int expect_cycles;
        int cycles;
        expect_cycles = line_cycles(ax0, ay0, ax1, ay1);
        plot_line(ax0, ay0, ax1, ay1, c);
        @(posedge clk_pix);
        start <= 1'b1;
        x0    <= CORDW'(ax0);
        y0    <= CORDW'(ay0);
        x1    <= CORDW'(ax1);
        y1    <= CORDW'(ay1);
        cidx  <= CIDXW'(c);
        @(negedge clk_pix);
        assert (busy === 1'b0)
            else report_mismatch({test_name, " busy during start"}, 0, busy);
        @(posedge clk_pix);
        start <= 1'b0;
        @(negedge clk_pix);
        assert (busy === 1'b1 && done === 1'b0)
            else report_mismatch({test_name, " busy after start"}, 2'b10, {busy, done});
        cycles = 0;
        while (done !== 1'b1) begin
            if (poke && cycles == 2) begin
                @(posedge clk_pix);
                start <= 1'b1;  // second request, must be dropped
                x0    <= 16'sd0;
                y0    <= 16'sd119;
                x1    <= 16'sd159;
                y1    <= 16'sd0;
                cidx  <= 4'hf;  // random lines never use 15
            end
            if (poke && cycles == 3) begin
                @(posedge clk_pix);
                start <= 1'b0;
            end
            @(negedge clk_pix);
            cycles++;
            if (cycles > expect_cycles + 16) begin
                report_failure({test_name, ": done never arrived after the line started"});
            end
            assert (done === 1'b1 || busy === 1'b1)
                else report_mismatch({test_name, " busy held"}, 1, busy);
        end
        assert (cycles == expect_cycles)
            else report_mismatch({test_name, " done timing"}, expect_cycles, cycles);
        assert (busy === 1'b0)
            else report_mismatch({test_name, " busy at done"}, 0, busy);
    endtask

    // ask for the next whole frame and wait until it is compared
    task automatic check_next_frame();
        int target;
        target = frames_checked + 1;
        @(posedge clk_pix);
        frames_requested = frames_requested + 1;
        while (frames_checked < target) begin
            @(negedge clk_pix);
        end
    endtask

    // comparing process, tracks display position from de and vsync
    always @(negedge clk_pix) begin
        if (rst) begin
            row       = -1;
            col       = 0;
            hblank    = -1;
            capturing = 1'b0;
            prev_de   = 1'b0;
            prev_vs   = 1'b1;
        end else begin
            if (prev_vs && !vga_vsync) begin  // vsync falling, frame boundary
                if (capturing) begin
                    assert (row == V_ACTIVE)
                        else report_mismatch({test_name, " lines per frame"}, V_ACTIVE, row);
                    capturing = 1'b0;
                    frames_checked++;
                end
                row = 0;
            end
            if (vga_de && !prev_de) begin
                col = 0;
                if (row == 0 && !capturing && frames_requested > frames_started) begin
                    capturing = 1'b1;  // start at the top left pixel
                    frames_started++;
                end
            end
            if (vga_de) begin
                if (capturing) begin
                    exp_rgb = expected_rgb(col, row);
                    assert ({vga_r, vga_g, vga_b} === exp_rgb)
                        else report_mismatch($sformatf("%s pixel %0d,%0d", test_name, col, row),
                                             exp_rgb, {vga_r, vga_g, vga_b});
                end
                col++;
                hblank = -1;
            end else begin
                if (prev_de) begin  // de falling, end of a line
                    if (capturing) begin
                        assert (col == H_ACTIVE)
                            else report_mismatch({test_name, " pixels per line"}, H_ACTIVE, col);
                    end
                    if (row >= 0) row++;
                    hblank = 0;
                end
                // hsync pulse position in the blanking after each line
                if (hblank >= 0 && hblank < H_FP + H_SYNC + H_BP) begin
                    exp_hs = (hblank >= H_FP && hblank < H_FP + H_SYNC) ? SYNC_ACTIVE
                                                                        : ~SYNC_ACTIVE;
                    if (capturing) begin
                        assert (vga_hsync === exp_hs)
                            else report_mismatch(
                                $sformatf("%s hsync %0d after de", test_name, hblank),
                                exp_hs, vga_hsync);
                    end
                    hblank++;
                end
            end
            prev_de = vga_de;
            prev_vs = vga_vsync;
        end
    end

    initial begin
        int ax0, ay0, ax1, ay1, c;
        rst   = 1'b1;
        start = 1'b0;
        x0    = '0;
        y0    = '0;
        x1    = '0;
        y1    = '0;
        cidx  = '0;
        lfsr  = 32'd95341;
        for (int i = 0; i < FB_WIDTH*FB_HEIGHT; i++) begin
            shadow[i] = '0;  // background
        end
        repeat (3) @(posedge clk_pix);
        rst <= 1'b0;

        // outputs straight out of reset
        @(negedge clk_pix);
        assert (busy === 1'b0 && done === 1'b0)
            else report_mismatch("reset busy/done", 0, {busy, done});
        assert (vga_de === 1'b0) else report_mismatch("reset de", 0, vga_de);
        assert (vga_hsync === 1'b1 && vga_vsync === 1'b1)
            else report_mismatch("reset syncs", 2'b11, {vga_hsync, vga_vsync});
        assert ({vga_r, vga_g, vga_b} === '0)
            else report_mismatch("reset colour", 0, {vga_r, vga_g, vga_b});

        test_name = "diagonal";
        draw_line_checked(10, 0, 149, 119, 9, 1'b0);
        test_name = "diagonal frame";
        check_next_frame();

        test_name = "directions";
        draw_line_checked(20, 30, 140, 30, 3, 1'b0);     // horizontal
        draw_line_checked(80, 5, 80, 115, 11, 1'b0);     // vertical
        draw_line_checked(50, 50, 50, 50, 7, 1'b0);      // single point
        draw_line_checked(150, 100, 5, 90, 12, 1'b0);    // right to left
        draw_line_checked(30, 118, 45, 2, 14, 1'b0);     // bottom to top
        draw_line_checked(120, 110, 100, 10, 2, 1'b0);   // both reversed, steep
        check_next_frame();

        test_name = "random";
        repeat (20) begin
            ax0 = rand_bits(8) % FB_WIDTH;
            ay0 = rand_bits(7) % FB_HEIGHT;
            ax1 = rand_bits(8) % FB_WIDTH;
            ay1 = rand_bits(7) % FB_HEIGHT;
            c   = rand_bits(4) % 15;
            draw_line_checked(ax0, ay0, ax1, ay1, c, 1'b0);
        end
        check_next_frame();

        test_name = "start while busy";
        draw_line_checked(0, 60, 159, 60, 10, 1'b1);
        check_next_frame();

        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog, line budget plus four frames
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_pix);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- rtl/line_display_top.sv
// line drawing display subsystem
// draw_line writes the framebuffer, vga_scanout reads it out at 640x480
module line_display_top import gfx_pkg::*; (
    input  logic                    clk_pix,
    input  logic                    rst,
    input  logic                    start,
    input  logic signed [CORDW-1:0] x0,
    input  logic signed [CORDW-1:0] y0,
    input  logic signed [CORDW-1:0] x1,
    input  logic signed [CORDW-1:0] y1,
    input  logic [CIDXW-1:0]        cidx,
    output logic                    busy,
    output logic                    done,
    output logic                    vga_hsync,
    output logic                    vga_vsync,
    output logic                    vga_de,
    output logic [CHANW-1:0]        vga_r,
    output logic [CHANW-1:0]        vga_g,
    output logic [CHANW-1:0]        vga_b
);

    // producer to framebuffer
    logic             fb_we;
    logic [FB_XW-1:0] fb_wx;
    logic [FB_YW-1:0] fb_wy;
    logic [CIDXW-1:0] fb_wcidx;

    // scanout to framebuffer and back
    logic [FB_XW-1:0] fb_rx;
    logic [FB_YW-1:0] fb_ry;
    logic [CHANW-1:0] fb_red, fb_green, fb_blue;

    draw_line u_draw_line (
        .clk_pix, .rst, .start,
        .x0, .y0, .x1, .y1, .cidx,
        .we(fb_we), .wx(fb_wx), .wy(fb_wy), .wcidx(fb_wcidx),
        .busy, .done
    );

    framebuffer u_framebuffer (
        .clk_pix,
        .we(fb_we), .wx(fb_wx), .wy(fb_wy), .wcidx(fb_wcidx),
        .rx(fb_rx), .ry(fb_ry),
        .red(fb_red), .green(fb_green), .blue(fb_blue)
    );

    vga_scanout u_vga_scanout (
        .clk_pix, .rst,
        .red(fb_red), .green(fb_green), .blue(fb_blue),
        .rx(fb_rx), .ry(fb_ry),
        .hsync(vga_hsync), .vsync(vga_vsync), .de(vga_de),
        .r(vga_r), .g(vga_g), .b(vga_b)
    );

endmodule

//--- rtl/vga_scanout.sv
// 640x480 display timing and framebuffer scanout at scale 4
// sync and de delayed 3 cycles to line up with palette colour
module vga_scanout import gfx_pkg::*, display_pkg::*; (
    input  logic              clk_pix,
    input  logic              rst,
    input  logic [CHANW-1:0]  red,    // from framebuffer, 2 cycles after rx/ry
    input  logic [CHANW-1:0]  green,
    input  logic [CHANW-1:0]  blue,
    output logic [FB_XW-1:0]  rx,
    output logic [FB_YW-1:0]  ry,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic [CHANW-1:0]  r,
    output logic [CHANW-1:0]  g,
    output logic [CHANW-1:0]  b
);

    logic [$clog2(H_TOTAL)-1:0] sx;  // 0..799
    logic [$clog2(V_TOTAL)-1:0] sy;  // 0..524
    logic hs_0, vs_0, de_0;           // decoded at the counters, cycle 0
    logic [2:0] hs_q, vs_q, de_q;     // bit 2 is cycle 3

    // screen position
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == H_TOTAL-1) begin
            sx <= '0;
            sy <= (sy == V_TOTAL-1) ? '0 : sy + 1'b1;  // wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    always_comb begin
        hs_0 = (sx >= H_ACTIVE+H_FP && sx < H_ACTIVE+H_FP+H_SYNC) ? SYNC_ACTIVE
                                                                 : ~SYNC_ACTIVE;
        vs_0 = (sy >= V_ACTIVE+V_FP && sy < V_ACTIVE+V_FP+V_SYNC) ? SYNC_ACTIVE
                                                                 : ~SYNC_ACTIVE;
        de_0 = (sx < H_ACTIVE) && (sy < V_ACTIVE);
    end

    // cycle 1: scaled read coordinates, held at 0 in blanking
    always_ff @(posedge clk_pix) begin
        rx <= (sx < H_ACTIVE) ? FB_XW'(sx / FB_SCALE) : '0;
        ry <= (sy < V_ACTIVE) ? FB_YW'(sy / FB_SCALE) : '0;
    end

    // match the rx/ry, memory and palette stages
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            hs_q <= {3{~SYNC_ACTIVE}};
            vs_q <= {3{~SYNC_ACTIVE}};
            de_q <= '0;
        end else begin
            hs_q <= {hs_q[1:0], hs_0};
            vs_q <= {vs_q[1:0], vs_0};
            de_q <= {de_q[1:0], de_0};
        end
    end

    assign hsync = hs_q[2];
    assign vsync = vs_q[2];
    assign de    = de_q[2];

    // blank colour outside the active area
    assign r = de ? red   : '0;
    assign g = de ? green : '0;
    assign b = de ? blue  : '0;

    // delayed active video never overlaps a delayed sync pulse
    a_de_no_sync: assert property (@(posedge clk_pix) disable iff (rst)
        de |-> (hsync != SYNC_ACTIVE && vsync != SYNC_ACTIVE));

endmodule

//--- rtl/framebuffer.sv
// colour-index framebuffer, 160x120 by 4 bits
// one write port, registered read port, then a registered palette lookup
module framebuffer import gfx_pkg::*; (
    input  logic              clk_pix,
    input  logic              we,
    input  logic [FB_XW-1:0]  wx,
    input  logic [FB_YW-1:0]  wy,
    input  logic [CIDXW-1:0]  wcidx,
    input  logic [FB_XW-1:0]  rx,
    input  logic [FB_YW-1:0]  ry,
    output logic [CHANW-1:0]  red,
    output logic [CHANW-1:0]  green,
    output logic [CHANW-1:0]  blue
);

    logic [CIDXW-1:0]    mem [FB_WIDTH*FB_HEIGHT];
    logic [FB_ADDRW-1:0] waddr;
    logic [FB_ADDRW-1:0] raddr;
    logic [CIDXW-1:0]    cidx_rd;  // read data, one cycle after rx/ry

    // row-major address
    function automatic logic [FB_ADDRW-1:0] xy_addr(
        input logic [FB_XW-1:0] x,
        input logic [FB_YW-1:0] y
    );
        return FB_ADDRW'(y * FB_WIDTH + x);
    endfunction

    assign waddr = xy_addr(wx, wy);
    assign raddr = xy_addr(rx, ry);

    // whole buffer starts as background
    initial begin
        for (int i = 0; i < FB_WIDTH*FB_HEIGHT; i++) begin
            mem[i] = '0;
        end
    end

    // same-address read and write in one cycle returns the old index
    always_ff @(posedge clk_pix) begin
        if (we) mem[waddr] <= wcidx;
        cidx_rd <= mem[raddr];
    end

    // palette stage
    always_ff @(posedge clk_pix) begin
        {red, green, blue} <= palette_rgb(cidx_rd);
    end

    a_waddr_range: assert property (@(posedge clk_pix)
        we |-> (waddr < FB_ADDRW'(FB_WIDTH*FB_HEIGHT)));

endmodule

//--- rtl/draw_line.sv
// Bresenham line producer
// latches a line on start, then emits one framebuffer write per cycle
module draw_line import gfx_pkg::*; (
    input  logic                    clk_pix,
    input  logic                    rst,
    input  logic                    start,   // one-cycle request
    input  logic signed [CORDW-1:0] x0,
    input  logic signed [CORDW-1:0] y0,
    input  logic signed [CORDW-1:0] x1,
    input  logic signed [CORDW-1:0] y1,
    input  logic [CIDXW-1:0]        cidx,
    output logic                    we,
    output logic [FB_XW-1:0]        wx,
    output logic [FB_YW-1:0]        wy,
    output logic [CIDXW-1:0]        wcidx,
    output logic                    busy,
    output logic                    done     // pulse after last write
);

    typedef enum logic {IDLE, DRAW} state_t;
    state_t state;

    logic go;                          // accepted request
    logic signed [CORDW-1:0] x, y;     // current point
    logic signed [CORDW-1:0] xe, ye;   // end point
    logic signed [CORDW:0]   dx, dy;   // |dx| and -|dy|
    logic signed [CORDW:0]   err;
    logic                    x_inc, y_inc;
    logic [CIDXW-1:0]        cidx_q;

    logic signed [CORDW:0]   dx_in, dy_in;  // raw differences at start
    logic signed [CORDW+1:0] e2;
    logic                    step_x, step_y;
    logic                    at_end;

    assign go = start && (state == IDLE);  // requests while busy dropped

    always_comb begin
        dx_in  = x1 - x0;  // sign-extended to CORDW+1
        dy_in  = y1 - y0;
        e2     = err <<< 1;
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
        at_end = (x == xe) && (y == ye);
    end

    // control
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (go) state <= DRAW;
                DRAW: begin
                    if (at_end) begin
                        state <= IDLE;
                        done  <= 1'b1;  // busy falls in the same cycle
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // datapath, loaded on go and stepped while drawing
    always_ff @(posedge clk_pix) begin
        if (go) begin
            x      <= x0;
            y      <= y0;
            xe     <= x1;
            ye     <= y1;
            x_inc  <= (x1 >= x0);
            y_inc  <= (y1 >= y0);
            dx     <= (dx_in < 0) ? -dx_in : dx_in;
            dy     <= (dy_in < 0) ? dy_in : -dy_in;  // kept negative
            err    <= ((dx_in < 0) ? -dx_in : dx_in) + ((dy_in < 0) ? dy_in : -dy_in);
            cidx_q <= cidx;
        end else if (state == DRAW && !at_end) begin
            if (step_x) x <= x_inc ? x + 1'b1 : x - 1'b1;
            if (step_y) y <= y_inc ? y + 1'b1 : y - 1'b1;
            err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
        end
    end

    assign we    = (state == DRAW);  // current point is written every draw cycle
    assign busy  = (state == DRAW);
    assign wx    = x[FB_XW-1:0];
    assign wy    = y[FB_YW-1:0];
    assign wcidx = cidx_q;

    // full coordinate checked before truncation to fb width
    a_wr_in_fb: assert property (@(posedge clk_pix) disable iff (rst)
        we |-> (x >= 0 && x < FB_WIDTH && y >= 0 && y < FB_HEIGHT));

    a_done_pulse: assert property (@(posedge clk_pix) disable iff (rst)
        done |=> !done);

endmodule

//--- rtl/display_pkg.sv
// 640x480 display timing, 800x525 total at the pixel clock
// sync pulses are active low for this mode
package display_pkg;

    // horizontal, in pixels
    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BP     = 48;
    localparam int H_TOTAL  = 800;  // active + fp + sync + bp

    // vertical, in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 33;
    localparam int V_TOTAL  = 525;

    localparam logic SYNC_ACTIVE = 1'b0;  // level during the sync pulse

endpackage

//--- rtl/gfx_pkg.sv
// graphics definitions shared by the line producer, framebuffer and scanout
// coordinate and colour widths, framebuffer geometry, 16-entry palette
package gfx_pkg;

    localparam int CORDW     = 16;   // signed drawing coordinates
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_SCALE  = 4;    // display pixels per fb pixel, each axis
    localparam int FB_ADDRW  = 15;   // 160*120 = 19200 entries
    localparam int FB_XW     = 8;    // fb column, 0..159
    localparam int FB_YW     = 7;    // fb row, 0..119
    localparam int CIDXW     = 4;    // colour index
    localparam int CHANW     = 4;    // per channel

    // index to packed {red, green, blue}
    function automatic logic [3*CHANW-1:0] palette_rgb(input logic [CIDXW-1:0] idx);
        case (idx)
            4'h0:    return 12'h000;  // black, background
            4'h1:    return 12'h126;  // dark blue
            4'h2:    return 12'h724;  // purple
            4'h3:    return 12'h085;  // dark green
            4'h4:    return 12'ha53;  // brown
            4'h5:    return 12'h555;  // dark grey
            4'h6:    return 12'hccc;  // light grey
            4'h7:    return 12'hfff;  // white
            4'h8:    return 12'hf04;  // red
            4'h9:    return 12'hfa0;  // orange
            4'ha:    return 12'hff2;  // yellow
            4'hb:    return 12'h0e3;  // green
            4'hc:    return 12'h2af;  // blue
            4'hd:    return 12'h879;  // lavender
            4'he:    return 12'hf7a;  // pink
            default: return 12'hfca;  // peach
        endcase
    endfunction

endpackage
